//--- verilog/axi_rd_cfg_pkg.sv
// Fixed configuration of the multi-channel AXI4 read master
// Bus widths, channel count, burst geometry and outstanding limit

package axi_rd_cfg_pkg;

  // AXI bus geometry
  localparam int ADDR_W       = 32;
  localparam int DATA_W       = 32;
  localparam int DW_BYTES     = 4;
  localparam int LOG_DW_BYTES = 2;

  // Channels, one AXI ID each
  localparam int NUM_CH = 2;
  localparam int ID_W   = 1;

  // Width of the byte count on the command
  localparam int XFER_W = 32;

  // Burst shape and flow control
  localparam int BURST_LEN       = 16;
  localparam int LOG_BURST_LEN   = 4;
  localparam int BURST_BYTES     = 64;
  localparam int MAX_OUTSTANDING = 4;
  localparam int CREDIT_W        = 3;
  localparam int FIFO_DEPTH      = BURST_LEN * MAX_OUTSTANDING;
  localparam int ARSIZE_VAL      = 2;

endpackage : axi_rd_cfg_pkg

//--- verilog/axi_rd_types_pkg.sv
// Data, address, ID and burst length types of the read master
// Also the beat count word that is decoded whole or as bursts plus tail

package axi_rd_types_pkg;

  import axi_rd_cfg_pkg::*;

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [DATA_W-1:0] data_t;
  typedef logic [ID_W-1:0]   id_t;

  // AXI burst length field, beats minus one
  typedef logic [7:0] arlen_t;

  // Full bursts that follow the first one
  typedef logic [XFER_W-LOG_DW_BYTES-LOG_BURST_LEN-1:0] burst_cnt_t;

  // Upper bits count bursts, lower bits give the tail length
  typedef struct packed {
    burst_cnt_t               bursts;
    logic [LOG_BURST_LEN-1:0] last_len;
  } beat_split_t;

  // Total beats minus one
  typedef union packed {
    logic [XFER_W-LOG_DW_BYTES-1:0] beats;
    beat_split_t                    split;
  } beat_cnt_u;

endpackage : axi_rd_types_pkg

//--- verilog/rd_cmd_setup.sv
// Command capture for the read master
// Rounds the byte count to beats and delays the start pulse

`timescale 1ns/1ps

module rd_cmd_setup
  import axi_rd_cfg_pkg::*, axi_rd_types_pkg::*;
(
  input  logic                   aclk,
  input  logic                   areset,
  input  logic                   ctrl_start,
  input  addr_t [NUM_CH-1:0]     ctrl_addr_offset,
  input  logic  [XFER_W-1:0]     ctrl_xfer_size,
  output logic                   start,
  output beat_cnt_u              beat_count,
  output addr_t [NUM_CH-1:0]     addr_offset
);

  logic start_d1;
  logic partial_beat;

  // A size with a byte remainder needs one more beat
  assign partial_beat = |ctrl_xfer_size[LOG_DW_BYTES-1:0];

  // Count and offsets hold until the next command
  always_ff @(posedge aclk) begin
    if (ctrl_start) begin
      if (partial_beat) begin
        beat_count.beats <= ctrl_xfer_size[XFER_W-1:LOG_DW_BYTES];
      end else begin
        beat_count.beats <= ctrl_xfer_size[XFER_W-1:LOG_DW_BYTES] - 1'b1;
      end
      addr_offset <= ctrl_addr_offset;
    end
  end

  // Start reaches the issuer once the count is settled
  always_ff @(posedge aclk) begin
    if (areset) begin
      start_d1 <= 1'b0;
      start    <= 1'b0;
    end else begin
      start_d1 <= ctrl_start;
      start    <= start_d1;
    end
  end

endmodule : rd_cmd_setup

//--- verilog/ar_issuer.sv
// AR channel issuer with per-channel address and burst counters
// Channels take turns by rotating the AXI ID

`timescale 1ns/1ps

module ar_issuer
  import axi_rd_cfg_pkg::*, axi_rd_types_pkg::*;
(
  input  logic               aclk,
  input  logic               areset,
  input  logic               start,
  input  beat_cnt_u          beat_count,
  input  addr_t [NUM_CH-1:0] addr_offset,
  input  logic  [NUM_CH-1:0] stall,
  output logic  [NUM_CH-1:0] ar_accept,
  output logic               m_axi_arvalid,
  input  logic               m_axi_arready,
  output addr_t              m_axi_araddr,
  output id_t                m_axi_arid,
  output arlen_t             m_axi_arlen,
  output logic  [2:0]        m_axi_arsize
);

  logic                    arvalid_r;
  id_t                     id;
  id_t                     next_id;
  logic       [NUM_CH-1:0] idle;
  addr_t      [NUM_CH-1:0] next_addr;
  burst_cnt_t [NUM_CH-1:0] bursts_left;
  logic       [NUM_CH-1:0] final_burst;

  ////////////////////////////////////////////////////////////////////////////
  // Per-channel state
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    for (int i = 0; i < NUM_CH; i++) begin
      ar_accept[i]   = arvalid_r & m_axi_arready & (id == id_t'(i));
      final_burst[i] = (bursts_left[i] == '0);
    end
  end

  always_ff @(posedge aclk) begin
    for (int i = 0; i < NUM_CH; i++) begin
      if (areset) begin
        idle[i]        <= 1'b1;
        bursts_left[i] <= '0;
      end else if (start) begin
        idle[i]        <= 1'b0;
        bursts_left[i] <= beat_count.split.bursts;
      end else if (ar_accept[i]) begin
        // Last request of the channel sends it back to idle
        if (final_burst[i]) begin
          idle[i] <= 1'b1;
        end else begin
          bursts_left[i] <= bursts_left[i] - 1'b1;
        end
      end
    end
  end

  // Address of the next burst, one burst size per accepted request
  always_ff @(posedge aclk) begin
    for (int i = 0; i < NUM_CH; i++) begin
      if (start) begin
        next_addr[i] <= addr_offset[i];
      end else if (ar_accept[i]) begin
        next_addr[i] <= next_addr[i] + ADDR_W'(BURST_BYTES);
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // ID rotation and request
  ////////////////////////////////////////////////////////////////////////////

  assign next_id = (id == '0) ? id_t'(NUM_CH - 1) : id - 1'b1;

  // Skip a channel that has nothing to send or no credit
  always_ff @(posedge aclk) begin
    if (areset) begin
      arvalid_r <= 1'b0;
      id        <= id_t'(NUM_CH - 1);
    end else if (arvalid_r) begin
      if (m_axi_arready) begin
        arvalid_r <= 1'b0;
        id        <= next_id;
      end
    end else if (idle[id] | stall[id]) begin
      id <= next_id;
    end else begin
      arvalid_r <= 1'b1;
    end
  end

  assign m_axi_arvalid = arvalid_r;
  assign m_axi_araddr  = next_addr[id];
  assign m_axi_arid    = id;
  assign m_axi_arsize  = 3'(ARSIZE_VAL);

  // The tail length also covers a single-burst command
  assign m_axi_arlen = final_burst[id] ? arlen_t'(beat_count.split.last_len)
                                       : arlen_t'(BURST_LEN - 1);

  a_ar_hold : assert property (
    @(posedge aclk) disable iff (areset)
    m_axi_arvalid && !m_axi_arready |=> m_axi_arvalid && $stable(m_axi_araddr)
      && $stable(m_axi_arid) && $stable(m_axi_arlen)
  );

endmodule : ar_issuer

//--- verilog/burst_credits.sv
// Outstanding burst credits per channel
// Credits return as whole bursts leave on the stream side

`timescale 1ns/1ps

module burst_credits
  import axi_rd_cfg_pkg::*;
(
  input  logic              aclk,
  input  logic              areset,
  input  logic [NUM_CH-1:0] ar_accept,
  input  logic [NUM_CH-1:0] m_axis_tvalid,
  input  logic [NUM_CH-1:0] m_axis_tready,
  input  logic [NUM_CH-1:0] m_axis_tlast,
  output logic [NUM_CH-1:0] stall
);

  logic [NUM_CH-1:0][CREDIT_W-1:0]      vacancy;
  logic [NUM_CH-1:0][LOG_BURST_LEN-1:0] beat_cnt;
  logic [NUM_CH-1:0]                    beat;
  logic [NUM_CH-1:0]                    give;

  // A burst is consumed on its 16th beat or on the channel's tlast
  always_comb begin
    for (int i = 0; i < NUM_CH; i++) begin
      beat[i]  = m_axis_tvalid[i] & m_axis_tready[i];
      give[i]  = beat[i] & ((beat_cnt[i] == LOG_BURST_LEN'(BURST_LEN - 1)) | m_axis_tlast[i]);
      stall[i] = (vacancy[i] == '0);
    end
  end

  always_ff @(posedge aclk) begin
    for (int i = 0; i < NUM_CH; i++) begin
      if (areset) begin
        beat_cnt[i] <= '0;
      end else if (give[i]) begin
        beat_cnt[i] <= '0;
      end else if (beat[i]) begin
        beat_cnt[i] <= beat_cnt[i] + 1'b1;
      end
    end
  end

  // Take and return may land on the same cycle
  always_ff @(posedge aclk) begin
    for (int i = 0; i < NUM_CH; i++) begin
      if (areset) begin
        vacancy[i] <= CREDIT_W'(MAX_OUTSTANDING);
      end else begin
        vacancy[i] <= vacancy[i] - CREDIT_W'(ar_accept[i]) + CREDIT_W'(give[i]);
      end
    end
  end

  for (genvar g = 0; g < NUM_CH; g++) begin : g_chk
    a_vacancy_max : assert property (
      @(posedge aclk) disable iff (areset)
      vacancy[g] <= CREDIT_W'(MAX_OUTSTANDING)
    );
  end

endmodule : burst_credits

//--- verilog/r_channel_demux.sv
// R channel steering by ID into the per-channel FIFOs
// Tracks bursts left per channel and raises ctrl_done

`timescale 1ns/1ps

module r_channel_demux
  import axi_rd_cfg_pkg::*, axi_rd_types_pkg::*;
(
  input  logic              aclk,
  input  logic              areset,
  input  logic              start,
  input  beat_cnt_u         beat_count,
  input  logic              m_axi_rvalid,
  output logic              m_axi_rready,
  input  data_t             m_axi_rdata,
  input  logic              m_axi_rlast,
  input  id_t               m_axi_rid,
  output logic [NUM_CH-1:0] wr_en,
  output data_t             wr_data,
  output logic [NUM_CH-1:0] wr_last,
  output logic              ctrl_done
);

  burst_cnt_t [NUM_CH-1:0] bursts_left;
  logic       [NUM_CH-1:0] final_burst;
  logic       [NUM_CH-1:0] burst_end;
  logic       [NUM_CH-1:0] done;

  // FIFOs are sized for every burst in flight
  assign m_axi_rready = 1'b1;
  assign wr_data      = m_axi_rdata;

  always_comb begin
    for (int i = 0; i < NUM_CH; i++) begin
      wr_en[i]       = m_axi_rvalid & (m_axi_rid == id_t'(i));
      final_burst[i] = (bursts_left[i] == '0);
      burst_end[i]   = wr_en[i] & m_axi_rlast;
      wr_last[i]     = burst_end[i] & final_burst[i];
    end
  end

  always_ff @(posedge aclk) begin
    for (int i = 0; i < NUM_CH; i++) begin
      if (areset) begin
        bursts_left[i] <= '0;
      end else if (start) begin
        bursts_left[i] <= beat_count.split.bursts;
      end else if (burst_end[i] && !final_burst[i]) begin
        bursts_left[i] <= bursts_left[i] - 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Completion
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge aclk) begin
    for (int i = 0; i < NUM_CH; i++) begin
      if (areset || ctrl_done) begin
        done[i] <= 1'b0;
      end else if (wr_last[i]) begin
        done[i] <= 1'b1;
      end
    end
  end

  // High for the single cycle in which every flag is set
  assign ctrl_done = &done;

  // No beat arrives for a channel that already took its final burst
  a_rid_active : assert property (
    @(posedge aclk) disable iff (areset)
    m_axi_rvalid |-> !done[m_axi_rid]
  );

endmodule : r_channel_demux

//--- verilog/stream_fifo.sv
// First-word-fall-through FIFO for one stream channel
// Stores data together with its last flag

`timescale 1ns/1ps

module stream_fifo
  import axi_rd_cfg_pkg::*, axi_rd_types_pkg::*;
(
  input  logic  aclk,
  input  logic  areset,
  input  logic  wr_en,
  input  data_t wr_data,
  input  logic  wr_last,
  output logic  tvalid,
  input  logic  tready,
  output data_t tdata,
  output logic  tlast
);

  data_t mem_data [FIFO_DEPTH];
  logic  mem_last [FIFO_DEPTH];

  // One extra pointer bit tells full from empty
  logic [$clog2(FIFO_DEPTH):0] wr_ptr;
  logic [$clog2(FIFO_DEPTH):0] rd_ptr;
  logic                        full;

  always_ff @(posedge aclk) begin
    if (wr_en) begin
      mem_data[wr_ptr[$clog2(FIFO_DEPTH)-1:0]] <= wr_data;
      mem_last[wr_ptr[$clog2(FIFO_DEPTH)-1:0]] <= wr_last;
    end
  end

  always_ff @(posedge aclk) begin
    if (areset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (tvalid && tready) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  assign full = (wr_ptr[$clog2(FIFO_DEPTH)] != rd_ptr[$clog2(FIFO_DEPTH)])
             && (wr_ptr[$clog2(FIFO_DEPTH)-1:0] == rd_ptr[$clog2(FIFO_DEPTH)-1:0]);

  // Head entry is always on the outputs
  assign tvalid = (wr_ptr != rd_ptr);
  assign tdata  = mem_data[rd_ptr[$clog2(FIFO_DEPTH)-1:0]];
  assign tlast  = mem_last[rd_ptr[$clog2(FIFO_DEPTH)-1:0]];

  // Credits upstream must keep writes off a full FIFO
  a_no_overflow : assert property (
    @(posedge aclk) disable iff (areset)
    wr_en |-> !full
  );

endmodule : stream_fifo

//--- verilog/axi_read_master.sv
// Top of the multi-channel AXI4 read master
// Command setup, AR issue, credits, R steering and stream FIFOs

`timescale 1ns/1ps

module axi_read_master
  import axi_rd_cfg_pkg::*, axi_rd_types_pkg::*;
(
  input  logic               aclk,
  input  logic               areset,
  input  logic               ctrl_start,
  input  addr_t [NUM_CH-1:0] ctrl_addr_offset,
  input  logic  [XFER_W-1:0] ctrl_xfer_size,
  output logic               ctrl_done,
  output logic               m_axi_arvalid,
  input  logic               m_axi_arready,
  output addr_t              m_axi_araddr,
  output id_t                m_axi_arid,
  output arlen_t             m_axi_arlen,
  output logic  [2:0]        m_axi_arsize,
  input  logic               m_axi_rvalid,
  output logic               m_axi_rready,
  input  data_t              m_axi_rdata,
  input  logic               m_axi_rlast,
  input  id_t                m_axi_rid,
  output logic  [NUM_CH-1:0] m_axis_tvalid,
  input  logic  [NUM_CH-1:0] m_axis_tready,
  output data_t [NUM_CH-1:0] m_axis_tdata,
  output logic  [NUM_CH-1:0] m_axis_tlast
);

  logic               start;
  beat_cnt_u          beat_count;
  addr_t [NUM_CH-1:0] addr_offset;
  logic  [NUM_CH-1:0] ar_accept;
  logic  [NUM_CH-1:0] stall;
  logic  [NUM_CH-1:0] wr_en;
  data_t              wr_data;
  logic  [NUM_CH-1:0] wr_last;

  rd_cmd_setup u_setup (
    .aclk, .areset, .ctrl_start, .ctrl_addr_offset, .ctrl_xfer_size,
    .start, .beat_count, .addr_offset
  );

  ar_issuer u_issuer (
    .aclk, .areset, .start, .beat_count, .addr_offset, .stall, .ar_accept,
    .m_axi_arvalid, .m_axi_arready, .m_axi_araddr, .m_axi_arid,
    .m_axi_arlen, .m_axi_arsize
  );

  burst_credits u_credits (
    .aclk, .areset, .ar_accept, .m_axis_tvalid, .m_axis_tready,
    .m_axis_tlast, .stall
  );

  r_channel_demux u_demux (
    .aclk, .areset, .start, .beat_count, .m_axi_rvalid, .m_axi_rready,
    .m_axi_rdata, .m_axi_rlast, .m_axi_rid, .wr_en, .wr_data, .wr_last,
    .ctrl_done
  );

  // One FIFO per channel, all fed from the shared R data
  for (genvar g = 0; g < NUM_CH; g++) begin : g_fifo
    stream_fifo u_fifo (
      .aclk    (aclk),
      .areset  (areset),
      .wr_en   (wr_en[g]),
      .wr_data (wr_data),
      .wr_last (wr_last[g]),
      .tvalid  (m_axis_tvalid[g]),
      .tready  (m_axis_tready[g]),
      .tdata   (m_axis_tdata[g]),
      .tlast   (m_axis_tlast[g])
    );
  end

endmodule : axi_read_master

//--- verification/axi_mem_model.sv
// AXI4 read slave model for the testbench
// Data equals the byte address, with random gaps and ID interleaving

`timescale 1ns/1ps

module axi_mem_model
  import axi_rd_cfg_pkg::*, axi_rd_types_pkg::*;
(
  input  logic   aclk,
  input  logic   areset,
  input  logic   arvalid,
  output logic   arready,
  input  addr_t  araddr,
  input  id_t    arid,
  input  arlen_t arlen,
  output logic   rvalid,
  input  logic   rready,
  output data_t  rdata,
  output logic   rlast,
  output id_t    rid
);

  // Pending bursts in arrival order, with the next beat of each
  addr_t  q_addr [$];
  id_t    q_id   [$];
  arlen_t q_len  [$];
  int     q_beat [$];

  int   seed = 73;
  int   cur;
  logic ar_hs;
  logic r_hs;

  // Oldest burst of another ID, else the oldest one, keeps order within an ID
  function automatic int pick_burst(input id_t last_id);
    for (int i = 0; i < q_id.size(); i++) begin
      if (q_id[i] != last_id) begin
        return i;
      end
    end
    return 0;
  endfunction

  initial begin
    arready = 1'b0;
    rvalid  = 1'b0;
    rdata   = '0;
    rlast   = 1'b0;
    rid     = '0;
    cur     = 0;
    forever begin
      // Handshakes seen here complete on the coming rising edge
      @(negedge aclk);
      ar_hs = arvalid & arready;
      r_hs  = rvalid & rready;
      if (ar_hs && !areset) begin
        q_addr.push_back(araddr);
        q_id.push_back(arid);
        q_len.push_back(arlen);
        q_beat.push_back(0);
      end
      @(posedge aclk);
      #1;
      if (areset) begin
        q_addr.delete();
        q_id.delete();
        q_len.delete();
        q_beat.delete();
        rvalid  = 1'b0;
        arready = 1'b0;
      end else begin
        if (r_hs) begin
          if (rlast) begin
            q_addr.delete(cur);
            q_id.delete(cur);
            q_len.delete(cur);
            q_beat.delete(cur);
          end else begin
            q_beat[cur]++;
          end
        end
        // A beat not yet taken holds as it is
        if (!(rvalid && !r_hs)) begin
          rvalid = 1'b0;
          if (q_addr.size() > 0 && ($random(seed) & 3) != 0) begin
            cur    = pick_burst(rid);
            rvalid = 1'b1;
            rid    = q_id[cur];
            rdata  = data_t'(q_addr[cur] + ADDR_W'(DW_BYTES * q_beat[cur]));
            rlast  = (q_beat[cur] == int'(q_len[cur]));
          end
        end
        arready = (($random(seed) & 3) != 0);
      end
    end
  end

endmodule : axi_mem_model

//--- verification/tb_axi_read_master.sv
// Testbench for the multi-channel AXI4 read master
// Command table loop, AR and stream scoreboards, compare tasks and report

`timescale 1ns/1ps

module tb_axi_read_master
  import axi_rd_cfg_pkg::*, axi_rd_types_pkg::*;
;

  typedef struct {
    int                 size;
    addr_t [NUM_CH-1:0] offs;
    int                 pct;
    int                 words;
    int                 bursts;
    arlen_t             tail;
  } row_t;

  logic               aclk;
  logic               areset;
  logic               ctrl_start;
  addr_t [NUM_CH-1:0] ctrl_addr_offset;
  logic  [XFER_W-1:0] ctrl_xfer_size;
  logic               ctrl_done;
  logic               m_axi_arvalid;
  logic               m_axi_arready;
  addr_t              m_axi_araddr;
  id_t                m_axi_arid;
  arlen_t             m_axi_arlen;
  logic  [2:0]        m_axi_arsize;
  logic               m_axi_rvalid;
  logic               m_axi_rready;
  data_t              m_axi_rdata;
  logic               m_axi_rlast;
  id_t                m_axi_rid;
  logic  [NUM_CH-1:0] m_axis_tvalid;
  logic  [NUM_CH-1:0] m_axis_tready;
  data_t [NUM_CH-1:0] m_axis_tdata;
  logic  [NUM_CH-1:0] m_axis_tlast;

  row_t               rows [$];
  addr_t [NUM_CH-1:0] cur_off;
  int                 cur_words;
  int                 cur_bursts;
  arlen_t             cur_tail;
  int                 tready_pct = 100;
  int                 seed = 73;

  // Scoreboard state per channel
  int   beat_idx [NUM_CH];
  int   burst_beats [NUM_CH];
  int   consumed [NUM_CH];
  int   ar_cnt [NUM_CH];
  int   r_count [NUM_CH];
  int   done_cnt;
  logic done_prev = 1'b0;

  int errors = 0;
  int row_errors = 0;
  int checks = 0;
  int tests_run = 0;
  bit timed_out = 0;

  axi_read_master dut (
    .aclk, .areset, .ctrl_start, .ctrl_addr_offset, .ctrl_xfer_size, .ctrl_done,
    .m_axi_arvalid, .m_axi_arready, .m_axi_araddr, .m_axi_arid, .m_axi_arlen,
    .m_axi_arsize, .m_axi_rvalid, .m_axi_rready, .m_axi_rdata, .m_axi_rlast,
    .m_axi_rid, .m_axis_tvalid, .m_axis_tready, .m_axis_tdata, .m_axis_tlast
  );

  axi_mem_model u_mem (
    .aclk    (aclk),
    .areset  (areset),
    .arvalid (m_axi_arvalid),
    .arready (m_axi_arready),
    .araddr  (m_axi_araddr),
    .arid    (m_axi_arid),
    .arlen   (m_axi_arlen),
    .rvalid  (m_axi_rvalid),
    .rready  (m_axi_rready),
    .rdata   (m_axi_rdata),
    .rlast   (m_axi_rlast),
    .rid     (m_axi_rid)
  );

  initial begin
    aclk = 1'b0;
    forever #50 aclk = ~aclk;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_data(input data_t got, input data_t exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      row_errors++;
      $display("error at %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_addr(input addr_t got, input addr_t exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      row_errors++;
      $display("error at %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_len(input arlen_t got, input arlen_t exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      row_errors++;
      $display("error at %0t: %s got %0d expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      row_errors++;
      $display("error at %0t: %s got %b expected %b", $time, what, got, exp);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Monitors on the falling edge of the clock
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_ar();
    int     ch;
    addr_t  exp_addr;
    arlen_t exp_len;
    ch = int'(m_axi_arid);
    if (ar_cnt[ch] >= cur_bursts) begin
      errors++;
      row_errors++;
      $display("error at %0t: extra AR on channel %0d", $time, ch);
    end else begin
      exp_addr = cur_off[ch] + ADDR_W'(BURST_BYTES * ar_cnt[ch]);
      exp_len  = (ar_cnt[ch] < cur_bursts - 1) ? arlen_t'(BURST_LEN - 1) : cur_tail;
      check_addr(m_axi_araddr, exp_addr, $sformatf("ch%0d araddr", ch));
      check_len(m_axi_arlen, exp_len, $sformatf("ch%0d arlen", ch));
      check_flag(m_axi_arsize == 3'(LOG_DW_BYTES), 1'b1, "arsize is 4 bytes");
    end
    ar_cnt[ch]++;
  endtask

  task automatic check_beat(input int ch);
    data_t exp;
    exp = data_t'(cur_off[ch] + ADDR_W'(DW_BYTES * beat_idx[ch]));
    if (beat_idx[ch] >= cur_words) begin
      errors++;
      row_errors++;
      $display("error at %0t: extra stream beat on channel %0d", $time, ch);
    end else begin
      check_data(m_axis_tdata[ch], exp, $sformatf("ch%0d tdata", ch));
      check_flag(m_axis_tlast[ch], beat_idx[ch] == cur_words - 1,
                 $sformatf("ch%0d tlast", ch));
    end
    beat_idx[ch]++;
    burst_beats[ch]++;
    if (burst_beats[ch] == BURST_LEN || m_axis_tlast[ch]) begin
      consumed[ch]++;
      burst_beats[ch] = 0;
    end
  endtask

  task automatic check_done();
    done_cnt++;
    if (done_prev) begin
      errors++;
      row_errors++;
      $display("error at %0t: ctrl_done high on two cycles in a row", $time);
    end
    for (int i = 0; i < NUM_CH; i++) begin
      check_flag(r_count[i] == cur_words, 1'b1, $sformatf("ch%0d R beats at done", i));
    end
  endtask

  always @(negedge aclk) begin
    if (!areset) begin
      if (m_axi_arvalid && m_axi_arready) begin
        check_ar();
      end
      if (m_axi_rvalid) begin
        check_flag(m_axi_rready, 1'b1, "rready while rvalid");
      end
      if (m_axi_rvalid && m_axi_rready) begin
        r_count[int'(m_axi_rid)]++;
      end
      for (int i = 0; i < NUM_CH; i++) begin
        if (m_axis_tvalid[i] && m_axis_tready[i]) begin
          check_beat(i);
        end
        if (ar_cnt[i] - consumed[i] > MAX_OUTSTANDING) begin
          errors++;
          row_errors++;
          $display("error at %0t: ch%0d has %0d bursts outstanding", $time, i,
                   ar_cnt[i] - consumed[i]);
        end
      end
      if (ctrl_done) begin
        check_done();
      end
      done_prev = ctrl_done;
    end
  end

  // Random stream back-pressure at the row's ready percentage
  always begin
    @(posedge aclk);
    #1;
    for (int i = 0; i < NUM_CH; i++) begin
      m_axis_tready[i] = ({$random(seed)} % 100) < tready_pct;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Command table and sequencing
  ////////////////////////////////////////////////////////////////////////////

  task automatic add_row(input int size, input addr_t off0, input addr_t off1, input int pct,
                         input int words, input int bursts, input arlen_t tail);
    row_t r;
    r.size   = size;
    r.offs   = {off1, off0};
    r.pct    = pct;
    r.words  = words;
    r.bursts = bursts;
    r.tail   = tail;
    rows.push_back(r);
  endtask

  function automatic bit streams_complete();
    for (int i = 0; i < NUM_CH; i++) begin
      if (beat_idx[i] < cur_words) begin
        return 0;
      end
    end
    return 1;
  endfunction

  task automatic wait_for_done(input int limit, output bit ok);
    int n;
    n = 0;
    while (done_cnt == 0 && n < limit) begin
      @(posedge aclk);
      n++;
    end
    ok = (done_cnt != 0);
    if (!ok) begin
      $display("timeout: ctrl_done did not pulse within %0d cycles", limit);
    end
  endtask

  task automatic wait_for_streams(input int limit, output bit ok);
    int n;
    n = 0;
    while (!streams_complete() && n < limit) begin
      @(posedge aclk);
      n++;
    end
    ok = streams_complete();
    if (!ok) begin
      $display("timeout: stream data still incomplete after %0d cycles", limit);
    end
  endtask

  task automatic run_row(input int t);
    bit ok;
    row_errors = 0;
    cur_off    = rows[t].offs;
    cur_words  = rows[t].words;
    cur_bursts = rows[t].bursts;
    cur_tail   = rows[t].tail;
    tready_pct = rows[t].pct;
    done_cnt   = 0;
    for (int i = 0; i < NUM_CH; i++) begin
      beat_idx[i]    = 0;
      burst_beats[i] = 0;
      consumed[i]    = 0;
      ar_cnt[i]      = 0;
      r_count[i]     = 0;
    end
    @(posedge aclk);
    #1;
    ctrl_addr_offset = rows[t].offs;
    ctrl_xfer_size   = XFER_W'(rows[t].size);
    ctrl_start       = 1'b1;
    @(posedge aclk);
    #1;
    ctrl_start = 1'b0;
    wait_for_done(20000, ok);
    if (ok) begin
      wait_for_streams(20000, ok);
    end
    if (ok) begin
      // A few idle cycles expose a stray second ctrl_done
      repeat (4) @(posedge aclk);
      check_flag(done_cnt == 1, 1'b1, "one ctrl_done per command");
      for (int i = 0; i < NUM_CH; i++) begin
        check_flag(ar_cnt[i] == cur_bursts, 1'b1, $sformatf("ch%0d AR count", i));
      end
    end else begin
      timed_out = 1;
    end
    tests_run++;
    if (ok && row_errors == 0) begin
      $display("test %0d: %0d bytes, %0d words per channel, ok", t, rows[t].size, cur_words);
    end else begin
      $display("test %0d: %0d bytes, %0d errors", t, rows[t].size, row_errors);
    end
  endtask

  initial begin
    areset           = 1'b1;
    ctrl_start       = 1'b0;
    ctrl_addr_offset = '0;
    ctrl_xfer_size   = '0;
    m_axis_tready    = '0;
    // Size, offsets, ready percent, words, bursts, final arlen
    add_row(7,    32'h0000_1000, 32'h0000_8000, 100, 2,   1,  8'd1);
    add_row(64,   32'h0000_2040, 32'h0001_0000, 100, 16,  1,  8'd15);
    add_row(1,    32'h0000_3000, 32'h0000_3100, 50,  1,   1,  8'd0);
    add_row(301,  32'h0004_0000, 32'h0005_0040, 70,  76,  5,  8'd11);
    add_row(130,  32'h0000_0100, 32'h0000_0800, 100, 33,  3,  8'd0);
    add_row(1000, 32'h0010_0000, 32'h0020_0000, 30,  250, 16, 8'd9);
    repeat (8) @(posedge aclk);
    #1;
    areset = 1'b0;
    @(negedge aclk);
    check_flag(m_axi_arvalid, 1'b0, "arvalid after reset");
    check_flag(ctrl_done, 1'b0, "ctrl_done after reset");
    for (int i = 0; i < NUM_CH; i++) begin
      check_flag(m_axis_tvalid[i], 1'b0, $sformatf("ch%0d tvalid after reset", i));
    end
    for (int t = 0; t < rows.size() && !timed_out; t++) begin
      run_row(t);
    end
    $display("tests run %0d, checks %0d, errors %0d", tests_run, checks, errors);
    if (errors == 0 && !timed_out) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule : tb_axi_read_master

//--- sim.f
verilog/axi_rd_cfg_pkg.sv
verilog/axi_rd_types_pkg.sv
verilog/rd_cmd_setup.sv
verilog/ar_issuer.sv
verilog/burst_credits.sv
verilog/r_channel_demux.sv
verilog/stream_fifo.sv
verilog/axi_read_master.sv
verification/axi_mem_model.sv
verification/tb_axi_read_master.sv

//--- Bender.yml
package:
  name: axi_read_master

sources:
  - verilog/axi_rd_cfg_pkg.sv
  - verilog/axi_rd_types_pkg.sv
  - verilog/rd_cmd_setup.sv
  - verilog/ar_issuer.sv
  - verilog/burst_credits.sv
  - verilog/r_channel_demux.sv
  - verilog/stream_fifo.sv
  - verilog/axi_read_master.sv
  - target: simulation
    files:
      - verification/axi_mem_model.sv
      - verification/tb_axi_read_master.sv
